// ==== vlog.f ====
+incdir+verification
logic/fp_pkg.sv
logic/univib.sv
logic/fp_wb_regs.sv
logic/fps.sv
logic/fp_mantissa.sv
logic/fpu_top.sv
verification/fpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fpu_tb
RTL_TOP ?= fpu_top
FLIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/fpu_ref.svh ====
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

// next state of the 32 bit Galois LFSR, the output bit is the old lsb
function automatic logic [31:0] galois_step(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h80200003;
	end
	return s >> 1;
endfunction

// shift left until bits 47 and 46 differ, then truncate and flag
// result layout is {sign, zero, unf, ovf, word}
function automatic logic [35:0] normalize_pack(input logic [47:0] acc_in, input int ex_in);
	logic [47:0] acc;
	int ex;
	logic [23:0] fr;
	logic [31:0] r;
	logic ov, un, z, sg;
	acc = acc_in;
	ex = ex_in;
	while (acc != '0 && acc[47] == acc[46]) begin
		acc = acc << 1;
		ex = ex - 1;
	end
	fr = acc[47:24];
	if (fr == '0 || ex < -128) begin
		r = '0;
		ov = 1'b0;
		un = (fr != '0);
		z = 1'b1;
		sg = 1'b0;
	end else begin
		r = {fr, ex[7:0]};
		ov = (ex > 127);
		un = 1'b0;
		z = 1'b0;
		sg = fr[23];
	end
	return {sg, z, un, ov, r};
endfunction

function automatic logic [35:0] ref_flt(input logic [31:0] i);
	return normalize_pack({i, 16'b0}, 31);
endfunction

// align the smaller exponent, at most 25 places, then add in 25 bits
function automatic logic [35:0] ref_add(input logic [31:0] a, input logic [31:0] b,
		input logic sub);
	longint fa, fb, s;
	int ea, eb, d, emax, ex;
	fa = longint'($signed(a[31:8]));
	fb = longint'($signed(b[31:8]));
	if (sub) begin
		fb = -fb;
	end
	ea = int'($signed(a[7:0]));
	eb = int'($signed(b[7:0]));
	d = ea - eb;
	if (d > 25) d = 25;
	if (d < -25) d = -25;
	if (d > 0) begin
		fb = fb >>> d;
	end else begin
		fa = fa >>> (-d);
	end
	emax = (ea > eb) ? ea : eb;
	s = fa + fb;
	ex = emax;
	if (s > 64'sd8388607 || s < -64'sd8388608) begin
		s = s >>> 1;
		ex = emax + 1;
	end
	return normalize_pack({s[23:0], 24'b0}, ex);
endfunction

function automatic logic [35:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
	longint p;
	p = longint'($signed(a[31:8])) * longint'($signed(b[31:8]));
	return normalize_pack(p[47:0], int'($signed(a[7:0])) + int'($signed(b[7:0])) + 1);
endfunction

`endif

// ==== verification/fpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

	localparam int N_RAND = 6;
	localparam int N_OPS = 14 + 4 * N_RAND;
	localparam int LIMIT = N_OPS * 120 * (fp_pkg::STROB_TICKS + 1);

	logic got_fp = 1'b0;
	logic _0_f_, cyc, stb, we;
	logic [2:0] adr;
	logic [31:0] dat_w;
	wire ack, fp_done;
	wire [31:0] dat_r;

	int cycles = 0;
	int done_cnt = 0;
	int ack_cnt = 0;
	int cmp_errors = 0;
	int proto_errors = 0;
	int xfers = 0;
	logic [31:0] seed;
	logic [31:0] scratch;
	logic [31:0] exp_q[$];
	logic [31:0] act_q[$];
	string tag_q[$];

	`include "fpu_ref.svh"

	fpu_top u_dut (
		.got_fp(got_fp),
		._0_f_(_0_f_),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.ack(ack),
		.dat_r(dat_r),
		.fp_done(fp_done)
	);

	always #10 got_fp = ~got_fp;

	always @(posedge got_fp) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: no finish after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// pulses counted mid cycle
	always @(negedge got_fp) begin
		if (fp_done) done_cnt = done_cnt + 1;
		if (ack) ack_cnt = ack_cnt + 1;
	end

	always @(posedge got_fp) begin : compare
		logic [31:0] e;
		logic [31:0] a;
		string t;
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			a = act_q.pop_front();
			t = tag_q.pop_front();
			if (e !== a) begin
				$display("ERROR %s: expected %h got %h", t, e, a);
				cmp_errors = cmp_errors + 1;
			end
		end
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], seed[0]};
			seed = galois_step(seed);
		end
		return r;
	endfunction

	// normalized word with the exponent narrowed by an arithmetic shift
	function automatic logic [31:0] rand_norm(input int eshift);
		logic [31:0] r;
		logic [23:0] f;
		logic signed [7:0] e;
		r = rand_bits(24);
		f = r[23:0];
		f[22] = ~f[23];
		r = rand_bits(8);
		e = r[7:0];
		e = e >>> eshift;
		return {f, e};
	endfunction

	function automatic logic [31:0] stat_of(input logic [35:0] e);
		logic [31:0] s;
		s = '0;
		s[fp_pkg::ST_OVF] = e[32];
		s[fp_pkg::ST_UNF] = e[33];
		s[fp_pkg::ST_ZERO] = e[34];
		s[fp_pkg::ST_SIGN] = e[35];
		return s;
	endfunction

	task automatic xfer(input logic w, input logic [2:0] a, input logic [31:0] d,
			output logic [31:0] q);
		int waits;
		waits = 0;
		@(posedge got_fp);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= w;
		adr <= a;
		dat_w <= d;
		do begin
			@(negedge got_fp);
			waits = waits + 1;
		end while (!ack && waits < 8);
		if (waits != 2) begin
			$display("ack came %0d cycles after stb instead of one", waits - 1);
			proto_errors = proto_errors + 1;
		end
		q = dat_r;
		@(posedge got_fp);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		@(negedge got_fp);
		if (ack) begin
			$display("ack held for more than one cycle");
			proto_errors = proto_errors + 1;
		end
		xfers = xfers + 1;
	endtask

	task automatic wr(input logic [2:0] a, input logic [31:0] d);
		xfer(1'b1, a, d, scratch);
	endtask

	task automatic rd_check(input logic [2:0] a, input logic [31:0] e, input string tag);
		logic [31:0] q;
		xfer(1'b0, a, 32'h0, q);
		exp_q.push_back(e);
		act_q.push_back(q);
		tag_q.push_back(tag);
	endtask

	task automatic run_op(input logic [1:0] op, input logic [31:0] a, input logic [31:0] b,
			input logic [35:0] e);
		int n;
		wr(fp_pkg::ADR_A, a);
		wr(fp_pkg::ADR_B, b);
		n = done_cnt;
		wr(fp_pkg::ADR_CTL, {30'b0, op});
		while (done_cnt == n) @(posedge got_fp);
		rd_check(fp_pkg::ADR_RES, e[31:0], "res");
		rd_check(fp_pkg::ADR_STAT, stat_of(e), "stat");
		if (done_cnt != n + 1) begin
			$display("fp_done pulsed %0d times for one start", done_cnt - n);
			proto_errors = proto_errors + 1;
		end
	endtask

	initial begin : stimulus
		logic [31:0] a, b;
		logic [35:0] e;
		int n;
		_0_f_ = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		seed = 32'd3;
		repeat (3) @(posedge got_fp);
		_0_f_ <= 1'b1;
		rd_check(fp_pkg::ADR_STAT, 32'h0, "stat");
		rd_check(fp_pkg::ADR_RES, 32'h0, "res");
		if (done_cnt != 0) begin
			$display("fp_done pulsed with no operation started");
			proto_errors = proto_errors + 1;
		end

		run_op(fp_pkg::OP_FLT, 32'h0, 32'h0, ref_flt(32'h0));
		run_op(fp_pkg::OP_FLT, 32'h1, 32'h0, ref_flt(32'h1));
		run_op(fp_pkg::OP_FLT, 32'hffffffff, 32'h0, ref_flt(32'hffffffff));
		run_op(fp_pkg::OP_FLT, 32'h80000000, 32'h0, ref_flt(32'h80000000));
		for (int k = 0; k < N_RAND; k++) begin
			a = rand_bits(32);
			run_op(fp_pkg::OP_FLT, a, 32'h0, ref_flt(a));
		end

		for (int k = 0; k < N_RAND; k++) begin
			a = rand_norm(2);
			b = rand_norm(2);
			run_op(fp_pkg::OP_AD, a, b, ref_add(a, b, 1'b0));
			a = rand_norm(2);
			b = rand_norm(2);
			run_op(fp_pkg::OP_SD, a, b, ref_add(a, b, 1'b1));
		end
		// far apart exponents, cancellation, carry out
		a = {24'h600000, 8'd40};
		b = {24'ha00000, 8'd0};
		run_op(fp_pkg::OP_AD, a, b, ref_add(a, b, 1'b0));
		a = rand_norm(2);
		run_op(fp_pkg::OP_SD, a, a, ref_add(a, a, 1'b1));
		a = {24'h600000, 8'd5};
		b = {24'h500000, 8'd5};
		run_op(fp_pkg::OP_AD, a, b, ref_add(a, b, 1'b0));

		for (int k = 0; k < N_RAND; k++) begin
			a = rand_norm(1);
			b = rand_norm(1);
			run_op(fp_pkg::OP_MW, a, b, ref_mul(a, b));
		end
		a = {24'h800000, 8'd0};
		run_op(fp_pkg::OP_MW, a, a, ref_mul(a, a));
		b = rand_norm(1);
		run_op(fp_pkg::OP_MW, 32'h0, b, ref_mul(32'h0, b));

		// exponent range edges
		a = {24'h400000, 8'd100};
		run_op(fp_pkg::OP_MW, a, a, ref_mul(a, a));
		a = {24'h400000, 8'h9c};
		run_op(fp_pkg::OP_MW, a, a, ref_mul(a, a));
		a = {24'h400000, 8'h7f};
		run_op(fp_pkg::OP_AD, a, a, ref_add(a, a, 1'b0));
		a = {24'h500000, 8'h80};
		b = {24'h400000, 8'h80};
		run_op(fp_pkg::OP_SD, a, b, ref_add(a, b, 1'b1));

		// writes during a multiply must be dropped
		a = rand_norm(1);
		b = rand_norm(1);
		wr(fp_pkg::ADR_A, a);
		wr(fp_pkg::ADR_B, b);
		n = done_cnt;
		wr(fp_pkg::ADR_CTL, {30'b0, fp_pkg::OP_MW});
		wr(fp_pkg::ADR_A, ~a);
		wr(fp_pkg::ADR_B, ~b);
		wr(fp_pkg::ADR_CTL, {30'b0, fp_pkg::OP_FLT});
		while (done_cnt == n) @(posedge got_fp);
		repeat (10) @(posedge got_fp);
		if (done_cnt != n + 1) begin
			$display("fp_done pulsed %0d times for one accepted start", done_cnt - n);
			proto_errors = proto_errors + 1;
		end
		e = ref_mul(a, b);
		rd_check(fp_pkg::ADR_RES, e[31:0], "res");
		rd_check(fp_pkg::ADR_A, a, "a_word");
		rd_check(fp_pkg::ADR_B, b, "b_word");
		rd_check(fp_pkg::ADR_CTL, {30'b0, fp_pkg::OP_MW}, "op");

		repeat (3) @(posedge got_fp);
		if (ack_cnt != xfers) begin
			$display("saw %0d acks for %0d transfers", ack_cnt, xfers);
			proto_errors = proto_errors + 1;
		end
		$display("errors: compare %0d, protocol %0d", cmp_errors, proto_errors);
		if (cmp_errors == 0 && proto_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/fpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
	input wire got_fp,
	input wire _0_f_,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [2:0] adr,
	input wire [31:0] dat_w,
	output wire ack,
	output wire [31:0] dat_r,
	output wire fp_done
);

	wire fp_pkg::fp_word_u a_word;
	wire fp_pkg::fp_word_u b_word;
	wire fp_pkg::fp_word_u res;
	wire [1:0] op;
	wire start, busy;
	wire ovf, unf, zero, sign;
	wire ld, neg_b, alt, sum, mac, nrm, fin;
	wire aligned, normed, mul_lsb;

	fp_wb_regs u_regs (
		.got_fp(got_fp),
		._0_f_(_0_f_),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.ack(ack),
		.dat_r(dat_r),
		.busy(busy),
		.done(fp_done),
		.res(res),
		.ovf(ovf),
		.unf(unf),
		.zero(zero),
		.sign(sign),
		.a_word(a_word),
		.b_word(b_word),
		.op(op),
		.start(start)
	);

	fps u_fps (
		.got_fp(got_fp),
		._0_f_(_0_f_),
		.start(start),
		.op(op),
		.aligned(aligned),
		.normed(normed),
		.mul_lsb(mul_lsb),
		.ld(ld),
		.neg_b(neg_b),
		.alt(alt),
		.sum(sum),
		.mac(mac),
		.nrm(nrm),
		.fin(fin),
		.busy(busy),
		.done(fp_done)
	);

	fp_mantissa u_man (
		.got_fp(got_fp),
		._0_f_(_0_f_),
		.a_word(a_word),
		.b_word(b_word),
		.ld(ld),
		.neg_b(neg_b),
		.alt(alt),
		.sum(sum),
		.mac(mac),
		.nrm(nrm),
		.fin(fin),
		.aligned(aligned),
		.normed(normed),
		.mul_lsb(mul_lsb),
		.res(res),
		.ovf(ovf),
		.unf(unf),
		.zero(zero),
		.sign(sign)
	);

endmodule

`default_nettype wire

// ==== logic/fp_mantissa.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_mantissa (
	input wire got_fp,
	input wire _0_f_,
	input wire fp_pkg::fp_word_u a_word,
	input wire fp_pkg::fp_word_u b_word,
	input wire ld,
	input wire neg_b,
	input wire alt,
	input wire sum,
	input wire mac,
	input wire nrm,
	input wire fin,
	output wire aligned,
	output wire normed,
	output wire mul_lsb,
	output fp_pkg::fp_word_u res,
	output logic ovf,
	output logic unf,
	output logic zero,
	output logic sign
);

	// double length accumulator, fraction in the upper half
	logic signed [2*fp_pkg::MAN_W-1:0] acc;
	// A fraction during alignment, multiplier during MW
	logic signed [fp_pkg::MAN_W-1:0] mq;
	logic signed [fp_pkg::MAN_W:0] bq;
	logic signed [fp_pkg::EXP_W+1:0] ex;
	// remaining alignment shifts, sign picks the operand
	logic signed [5:0] dif;
	logic fresh;

	logic signed [9:0] ea, eb, ed, emax;
	logic signed [24:0] bf, s, addend, t;
	logic signed [23:0] fr;

	assign ea = {{2{a_word.fval.expo[7]}}, a_word.fval.expo};
	assign eb = {{2{b_word.fval.expo[7]}}, b_word.fval.expo};
	assign ed = ea - eb;
	assign emax = (ea > eb) ? ea : eb;
	assign bf = {b_word.fval.frac[23], b_word.fval.frac};

	assign s = {mq[23], mq} + bq;
	assign addend = mul_lsb ? (neg_b ? -bq : bq) : 25'sd0;
	assign t = (fresh ? 25'sd0 : {acc[47], acc[47:24]}) + addend;
	assign fr = acc[47:24];

	assign aligned = (dif == 6'sd0);
	assign normed = (acc[47] ^ acc[46]) | (acc == '0);
	assign mul_lsb = mq[0];

	always_ff @(posedge got_fp) begin
		if (ld) begin
			// integer view as a 32 bit fraction with exponent 31
			acc <= {a_word.ival, 16'b0};
			ex <= 10'sd31;
			mq <= a_word.fval.frac;
			bq <= neg_b ? -bf : bf;
			dif <= (ed > 10'sd25) ? 6'sd25 : ((ed < -10'sd25) ? -6'sd25 : ed[5:0]);
			fresh <= 1'b1;
		end
		if (alt) begin
			if (dif > 6'sd0) begin
				bq <= bq >>> 1;
				dif <= dif - 6'sd1;
			end else begin
				mq <= mq >>> 1;
				dif <= dif + 6'sd1;
			end
		end
		if (sum) begin
			// carry out of 24 bits
			if (s[24] ^ s[23]) begin
				acc <= {s[24:1], 24'b0};
				ex <= emax + 10'sd1;
			end else begin
				acc <= {s[23:0], 24'b0};
				ex <= emax;
			end
		end
		if (mac) begin
			acc <= {t, (fresh ? 23'b0 : acc[23:1])};
			mq <= mq >>> 1;
			ex <= ea + eb + 10'sd1;
			fresh <= 1'b0;
		end
		if (nrm) begin
			acc <= acc <<< 1;
			ex <= ex - 10'sd1;
		end
	end

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			res <= '0;
			{ovf, unf, zero, sign} <= 4'b0;
		end else if (fin) begin
			if (fr == '0 || ex < -10'sd128) begin
				// canonical zero, flagged as underflow if it was not one
				res <= '0;
				ovf <= 1'b0;
				unf <= (fr != '0);
				zero <= 1'b1;
				sign <= 1'b0;
			end else begin
				res.fval.frac <= fr;
				res.fval.expo <= ex[7:0];
				ovf <= (ex > 10'sd127);
				unf <= 1'b0;
				zero <= 1'b0;
				sign <= fr[23];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/fps.sv ====
`timescale 1ns/1ps
`default_nettype none

module fps (
	input wire got_fp,
	input wire _0_f_,
	input wire start,
	input wire [1:0] op,
	input wire aligned,
	input wire normed,
	input wire mul_lsb,
	output wire ld,
	output wire neg_b,
	output wire alt,
	output wire sum,
	output wire mac,
	output wire nrm,
	output wire fin,
	output wire busy,
	output wire done
);

	// state flags, at most one set
	logic f_ld, f_al, f_sum, f_mul, f_nrm, f_fin;
	// multiply loop counter
	logic [4:0] lp;
	logic strob, strob_d;

	wire is_add = (op == fp_pkg::OP_AD) | (op == fp_pkg::OP_SD);
	wire is_sd = (op == fp_pkg::OP_SD);
	wire is_mw = (op == fp_pkg::OP_MW);
	wire is_flt = (op == fp_pkg::OP_FLT);

	// commands fire as the step strobe ends
	wire fall = strob_d & ~strob;
	wire last = (lp == 5'(fp_pkg::MAN_W - 1));
	wire step_trig = start | (fall & ~f_fin);

	univib #(
		.ticks(fp_pkg::STROB_TICKS)
	) u_strob (
		.got_fp(got_fp),
		._0_f_(_0_f_),
		.trig(step_trig),
		.q(strob)
	);

	univib #(
		.ticks(1)
	) u_done (
		.got_fp(got_fp),
		._0_f_(_0_f_),
		.trig(fin),
		.q(done)
	);

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			strob_d <= 1'b0;
		end else begin
			strob_d <= strob;
		end
	end

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			{f_ld, f_al, f_sum, f_mul, f_nrm, f_fin} <= 6'b0;
			lp <= '0;
		end else if (start) begin
			{f_ld, f_al, f_sum, f_mul, f_nrm, f_fin} <= 6'b100000;
			lp <= '0;
		end else if (fall) begin
			if (f_ld) begin
				f_ld <= 1'b0;
				f_al <= is_add;
				f_mul <= is_mw;
				f_nrm <= is_flt;
			end
			// wait for equal exponents
			if (f_al && aligned) begin
				f_al <= 1'b0;
				f_sum <= 1'b1;
			end
			if (f_sum) begin
				f_sum <= 1'b0;
				f_nrm <= 1'b1;
			end
			if (f_mul) begin
				lp <= lp + 5'd1;
				if (last) begin
					f_mul <= 1'b0;
					f_nrm <= 1'b1;
				end
			end
			if (f_nrm && normed) begin
				f_nrm <= 1'b0;
				f_fin <= 1'b1;
			end
			if (f_fin) begin
				f_fin <= 1'b0;
			end
		end
	end

	assign ld = fall & f_ld;
	assign alt = fall & f_al & ~aligned;
	assign sum = fall & f_sum;
	assign mac = fall & f_mul;
	assign nrm = fall & f_nrm & ~normed;
	assign fin = fall & f_fin;

	// negate B for SD, and subtract on the multiplier sign bit
	assign neg_b = (ld & is_sd) | (mac & last & mul_lsb);

	assign busy = f_ld | f_al | f_sum | f_mul | f_nrm | f_fin;

endmodule

`default_nettype wire

// ==== logic/fp_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_wb_regs (
	input wire got_fp,
	input wire _0_f_,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [2:0] adr,
	input wire [31:0] dat_w,
	output logic ack,
	output logic [31:0] dat_r,
	input wire busy,
	input wire done,
	input wire fp_pkg::fp_word_u res,
	input wire ovf,
	input wire unf,
	input wire zero,
	input wire sign,
	output fp_pkg::fp_word_u a_word,
	output fp_pkg::fp_word_u b_word,
	output logic [1:0] op,
	output logic start
);

	fp_pkg::fp_word_u res_r;
	logic st_ovf, st_unf, st_zero, st_sign;
	logic [31:0] stat;
	logic [31:0] rd_data;

	// one transfer per ack, no wait states
	wire req = cyc & stb & ~ack;
	// start counts as busy until the sequencer picks it up
	wire locked = busy | start;
	wire wr_ok = req & we & ~locked;

	always_comb begin
		stat = '0;
		stat[fp_pkg::ST_BUSY] = locked;
		stat[fp_pkg::ST_OVF] = st_ovf;
		stat[fp_pkg::ST_UNF] = st_unf;
		stat[fp_pkg::ST_ZERO] = st_zero;
		stat[fp_pkg::ST_SIGN] = st_sign;
		case (adr)
			fp_pkg::ADR_A: rd_data = a_word.ival;
			fp_pkg::ADR_B: rd_data = b_word.ival;
			fp_pkg::ADR_CTL: rd_data = {30'b0, op};
			fp_pkg::ADR_RES: rd_data = res_r.ival;
			fp_pkg::ADR_STAT: rd_data = stat;
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			ack <= 1'b0;
			dat_r <= '0;
			start <= 1'b0;
			op <= '0;
			a_word <= '0;
			b_word <= '0;
			res_r <= '0;
			{st_ovf, st_unf, st_zero, st_sign} <= 4'b0;
		end else begin
			ack <= req;
			start <= wr_ok & (adr == fp_pkg::ADR_CTL);
			if (wr_ok) begin
				case (adr)
					fp_pkg::ADR_A: a_word.ival <= dat_w;
					fp_pkg::ADR_B: b_word.ival <= dat_w;
					fp_pkg::ADR_CTL: op <= dat_w[1:0];
					default: ;
				endcase
			end
			if (req && !we) begin
				dat_r <= rd_data;
			end
			// result and flags of the finished operation
			if (done) begin
				res_r <= res;
				{st_ovf, st_unf, st_zero, st_sign} <= {ovf, unf, zero, sign};
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/univib.sv ====
`timescale 1ns/1ps
`default_nettype none

module univib #(
	parameter int ticks = 1
) (
	input wire got_fp,
	input wire _0_f_,
	input wire trig,
	output wire q
);

	localparam int CW = $clog2(ticks + 1);

	logic [CW-1:0] cnt;

	// retrigger reloads the full count
	always_ff @(posedge got_fp or negedge _0_f_) begin
		if (!_0_f_) begin
			cnt <= '0;
		end else if (trig) begin
			cnt <= CW'(ticks);
		end else if (cnt != '0) begin
			cnt <= cnt - CW'(1);
		end
	end

	assign q = (cnt != '0);

endmodule

`default_nettype wire

// ==== logic/fp_pkg.sv ====
`default_nettype none

package fp_pkg;

	// operation field of the control register
	localparam logic [1:0] OP_FLT = 2'd0;
	localparam logic [1:0] OP_AD = 2'd1;
	localparam logic [1:0] OP_SD = 2'd2;
	localparam logic [1:0] OP_MW = 2'd3;

	// bus word addresses
	localparam logic [2:0] ADR_A = 3'd0;
	localparam logic [2:0] ADR_B = 3'd1;
	localparam logic [2:0] ADR_CTL = 3'd2;
	localparam logic [2:0] ADR_RES = 3'd3;
	localparam logic [2:0] ADR_STAT = 3'd4;

	// status word bits
	localparam int ST_BUSY = 0;
	localparam int ST_OVF = 1;
	localparam int ST_UNF = 2;
	localparam int ST_ZERO = 3;
	localparam int ST_SIGN = 4;

	// length of one step strobe in clocks
	localparam int STROB_TICKS = 2;

	localparam int MAN_W = 24;
	localparam int EXP_W = 8;

	// operand word, integer for FLT, fraction and exponent otherwise
	typedef union packed {
		logic signed [31:0] ival;
		struct packed {
			logic signed [MAN_W-1:0] frac;
			logic signed [EXP_W-1:0] expo;
		} fval;
	} fp_word_u;

endpackage

`default_nettype wire
